// ==== hps_link_defs.svh ====
// widths shared by the host link RTL and its testbench
// words are 16 bits, the word index saturates at its maximum value
`ifndef HPS_LINK_DEFS_SVH
`define HPS_LINK_DEFS_SVH

////////////////////////////////////////////////////////////
// host word
////////////////////////////////////////////////////////////

// data width of io_din and io_dout
`define HPS_WORD_W 16

////////////////////////////////////////////////////////////
// transaction framing
////////////////////////////////////////////////////////////

// word position within one enable-framed transaction
// index 0 is always the command word
`define HPS_IDX_W 4

////////////////////////////////////////////////////////////
// status request reply
////////////////////////////////////////////////////////////

// upper nibble of the reply to a status request command
// the request counter sits right below it
`define HPS_REPLY_TAG 4'hA

`endif

// ==== hps_uio_pkg.sv ====
// user-I/O channel types, command codes follow the host firmware numbering
// only the commands kept in this link are listed
`include "hps_link_defs.svh"

package hps_uio_pkg;

	////////////////////////////////////////////////////////////
	// command opcodes
	////////////////////////////////////////////////////////////

	// first word of every user-I/O transaction
	typedef enum logic [`HPS_WORD_W-1:0] {
		// buttons and video switches
		CMD_CFG        = 16'h0001,
		// joystick 0, low half then high half
		CMD_JOY0       = 16'h0002,
		// joystick 1, same layout as joystick 0
		CMD_JOY1       = 16'h0003,
		// 64-bit status written by the host menu
		CMD_STATUS     = 16'h001E,
		// host reads back the status latched by the core
		CMD_STATUS_REQ = 16'h0029
	} uio_cmd_e;

	////////////////////////////////////////////////////////////
	// status word
	////////////////////////////////////////////////////////////

	// sent as four 16-bit slices, lowest slice first
	typedef logic [63:0] status_t;

endpackage

// ==== hps_fio_pkg.sv ====
// file download channel types, data is 8 bits wide
// the address steps by one byte per data word
`include "hps_link_defs.svh"

package hps_fio_pkg;

	////////////////////////////////////////////////////////////
	// file transfer opcodes
	////////////////////////////////////////////////////////////

	typedef enum logic [`HPS_WORD_W-1:0] {
		// start or stop, nonzero low byte starts
		FILE_TX     = 16'h0053,
		// payload words, low byte is the data
		FILE_TX_DAT = 16'h0054,
		// menu index of the file
		FILE_INDEX  = 16'h0055,
		// file extension, high half first
		FILE_INFO   = 16'h0056
	} fio_cmd_e;

	////////////////////////////////////////////////////////////
	// download address
	////////////////////////////////////////////////////////////

	// byte address into the core memory, up to 128 MB
	typedef logic [26:0] ioctl_addr_t;

endpackage

// ==== hps_word_framer.sv ====
// words are taken only while frame_en is high
// the index stops counting at its maximum and restarts when frame_en drops
`timescale 1ns/1ps
`include "hps_link_defs.svh"

module hps_word_framer (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   frame_en,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	output logic                   word_valid,
	output logic [`HPS_IDX_W-1:0]  word_idx,
	output logic [`HPS_WORD_W-1:0] word_data,
	output logic                   frame_open
);

	// position of the next word within the transaction
	logic [`HPS_IDX_W-1:0] word_cnt;
	logic                  take;

	assign take = frame_en & io_strobe;

	////////////////////////////////////////////////////////////
	// word capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			word_valid <= 1'b0;
			word_idx   <= '0;
			word_data  <= '0;
			word_cnt   <= '0;
			frame_open <= 1'b0;
		end else begin
			// one cycle pulse per strobed word
			word_valid <= take;
			// delayed enable, lines up with word_valid
			frame_open <= frame_en;

			if (!frame_en) begin
				word_cnt <= '0;
				word_idx <= '0;
			end else if (take) begin
				word_idx  <= word_cnt;
				word_data <= io_din;
				// saturate so long payloads stay at a nonzero index
				if (!(&word_cnt)) begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hps_user_regs.sv ====
// status readback returns the value latched at the last status_set edge
// io_dout holds until the next word and clears once the frame closes
`timescale 1ns/1ps
`include "hps_link_defs.svh"

module hps_user_regs (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   word_valid,
	input  logic [`HPS_IDX_W-1:0]  word_idx,
	input  logic [`HPS_WORD_W-1:0] word_data,
	input  logic                   frame_open,
	input  hps_uio_pkg::status_t   status_in,
	input  logic                   status_set,
	output logic [`HPS_WORD_W-1:0] io_dout,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output hps_uio_pkg::status_t   status
);

	import hps_uio_pkg::*;

	uio_cmd_e               cmd;
	uio_cmd_e               cmd_in;
	logic [`HPS_WORD_W-1:0] cfg;
	logic [`HPS_WORD_W-1:0] reply;
	logic [3:0]             req_cnt;
	status_t                status_req;
	logic                   status_set_d;

	// command word is decoded directly while cmd is being loaded
	assign cmd_in = uio_cmd_e'(word_data);

	// cfg bits 2, 3 and 5 and up belong to the video frame, not this link
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	////////////////////////////////////////////////////////////
	// status request capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_d <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			// rising edge only, a held level counts once
			if (status_set && !status_set_d) begin
				req_cnt    <= req_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// command decode and register writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd        <= uio_cmd_e'('0);
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word_valid) begin
			if (word_idx == '0) begin
				cmd <= cmd_in;
			end else begin
				case (cmd)
					CMD_CFG: begin
						if (word_idx == 4'd1) begin
							cfg <= word_data;
						end
					end
					// word 1 is the low half, anything after it the high half
					CMD_JOY0: begin
						if (word_idx == 4'd1) begin
							joystick_0[15:0] <= word_data;
						end else begin
							joystick_0[31:16] <= word_data;
						end
					end
					CMD_JOY1: begin
						if (word_idx == 4'd1) begin
							joystick_1[15:0] <= word_data;
						end else begin
							joystick_1[31:16] <= word_data;
						end
					end
					CMD_STATUS: begin
						case (word_idx)
							4'd1: status[15:0]  <= word_data;
							4'd2: status[31:16] <= word_data;
							4'd3: status[47:32] <= word_data;
							4'd4: status[63:48] <= word_data;
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// readback
	////////////////////////////////////////////////////////////

	always_comb begin
		reply = '0;
		if (word_idx == '0) begin
			// tag lets the host tell a live reply from an idle bus
			if (cmd_in == CMD_STATUS_REQ) begin
				reply = {8'd0, `HPS_REPLY_TAG, req_cnt};
			end
		end else if (cmd == CMD_STATUS_REQ) begin
			case (word_idx)
				4'd1: reply = status_req[15:0];
				4'd2: reply = status_req[31:16];
				4'd3: reply = status_req[47:32];
				4'd4: reply = status_req[63:48];
				default: reply = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_dout <= '0;
		end else if (!frame_open) begin
			io_dout <= '0;
		end else if (word_valid) begin
			io_dout <= reply;
		end
	end

endmodule

// ==== hps_file_loader.sv ====
// no back-pressure, the host must pace data words itself
// a stop leaves ioctl_addr at the last byte written
`timescale 1ns/1ps
`include "hps_link_defs.svh"

module hps_file_loader (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      word_valid,
	input  logic [`HPS_IDX_W-1:0]     word_idx,
	input  logic [`HPS_WORD_W-1:0]    word_data,
	output logic                      ioctl_download,
	output logic [7:0]                ioctl_index,
	output logic                      ioctl_wr,
	output hps_fio_pkg::ioctl_addr_t  ioctl_addr,
	output logic [7:0]                ioctl_dout,
	output logic [31:0]               ioctl_file_ext
);

	import hps_fio_pkg::*;

	fio_cmd_e    cmd;
	// address of the next data byte
	ioctl_addr_t addr;
	ioctl_addr_t addr_last;

	// empty download reports address 0
	assign addr_last = (addr == '0) ? '0 : addr - 1'b1;

	////////////////////////////////////////////////////////////
	// file command decode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd            <= fio_cmd_e'('0);
			addr           <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
		end else begin
			// write strobe is a single cycle
			ioctl_wr <= 1'b0;

			if (word_valid) begin
				if (word_idx == '0) begin
					cmd <= fio_cmd_e'(word_data);
				end else begin
					case (cmd)
						FILE_TX: begin
							if (|word_data[7:0]) begin
								addr           <= '0;
								ioctl_download <= 1'b1;
							end else begin
								ioctl_addr     <= addr_last;
								ioctl_download <= 1'b0;
							end
						end
						FILE_TX_DAT: begin
							ioctl_wr   <= 1'b1;
							ioctl_addr <= addr;
							ioctl_dout <= word_data[7:0];
							addr       <= addr + 1'b1;
						end
						FILE_INDEX: begin
							ioctl_index <= word_data[7:0];
						end
						// extension arrives high half first
						FILE_INFO: begin
							case (word_idx)
								4'd1: ioctl_file_ext[31:16] <= word_data;
								4'd2: ioctl_file_ext[15:0]  <= word_data;
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== hps_link_top.sv ====
// the host must not raise io_enable and fp_enable together
// every output trails its strobe by two clk_sys cycles
`timescale 1ns/1ps
`include "hps_link_defs.svh"

module hps_link_top (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     io_enable,
	input  logic                     fp_enable,
	input  logic                     io_strobe,
	input  logic [`HPS_WORD_W-1:0]   io_din,
	input  hps_uio_pkg::status_t     status_in,
	input  logic                     status_set,
	output logic [`HPS_WORD_W-1:0]   io_dout,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic [31:0]              joystick_0,
	output logic [31:0]              joystick_1,
	output hps_uio_pkg::status_t     status,
	output logic                     ioctl_download,
	output logic [7:0]               ioctl_index,
	output logic                     ioctl_wr,
	output hps_fio_pkg::ioctl_addr_t ioctl_addr,
	output logic [7:0]               ioctl_dout,
	output logic [31:0]              ioctl_file_ext
);

	logic                   uio_valid;
	logic [`HPS_IDX_W-1:0]  uio_idx;
	logic [`HPS_WORD_W-1:0] uio_data;
	logic                   uio_open;
	logic                   fio_valid;
	logic [`HPS_IDX_W-1:0]  fio_idx;
	logic [`HPS_WORD_W-1:0] fio_data;

	////////////////////////////////////////////////////////////
	// user-I/O path
	////////////////////////////////////////////////////////////

	hps_word_framer u_uio_framer (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.frame_en   (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.word_valid (uio_valid),
		.word_idx   (uio_idx),
		.word_data  (uio_data),
		.frame_open (uio_open)
	);

	hps_user_regs u_user_regs (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.word_valid         (uio_valid),
		.word_idx           (uio_idx),
		.word_data          (uio_data),
		.frame_open         (uio_open),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	////////////////////////////////////////////////////////////
	// download path
	////////////////////////////////////////////////////////////

	// the loader keys off the index alone, frame_open is not needed here
	hps_word_framer u_fio_framer (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.frame_en   (fp_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.word_valid (fio_valid),
		.word_idx   (fio_idx),
		.word_data  (fio_data),
		.frame_open ()
	);

	hps_file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.word_valid     (fio_valid),
		.word_idx       (fio_idx),
		.word_data      (fio_data),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

// ==== hps_link_chk.sv ====
// assertions bound into hps_link_top, fail_cnt counts every failed check
// io_dout must be idle once io_enable has been low for two cycles
`timescale 1ns/1ps
`include "hps_link_defs.svh"

module hps_link_chk (
	input logic                   clk_sys,
	input logic                   arst_n,
	input logic                   io_enable,
	input logic [`HPS_WORD_W-1:0] io_dout,
	input logic                   ioctl_wr,
	input logic                   ioctl_download
);

	// number of failed assertions so far
	int fail_cnt = 0;

	////////////////////////////////////////////////////////////
	// download strobes
	////////////////////////////////////////////////////////////

	wr_single_cycle: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |=> !ioctl_wr
	) else begin
		$error("ioctl_wr stayed high for more than one cycle");
		fail_cnt++;
	end

	// outputs stay inactive for the whole reset
	reset_quiet: assert property (
		@(posedge clk_sys)
		!arst_n |-> (!ioctl_download && !ioctl_wr)
	) else begin
		$error("download outputs active during reset");
		fail_cnt++;
	end

	////////////////////////////////////////////////////////////
	// user-I/O readback
	////////////////////////////////////////////////////////////

	// third low sample sees the value written after two low cycles
	dout_idle: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		(!io_enable) [*3] |-> (io_dout == '0)
	) else begin
		$error("io_dout not cleared after io_enable fell");
		fail_cnt++;
	end

endmodule

bind hps_link_top hps_link_chk u_chk (
	.clk_sys        (clk_sys),
	.arst_n         (arst_n),
	.io_enable      (io_enable),
	.io_dout        (io_dout),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

// ==== tb_hps_link.sv ====
// drives both host channels from a table, data words come from a seeded LFSR
// one channel enable at a time, words spaced by one idle cycle
`timescale 1ns/1ps
`include "hps_link_defs.svh"

module tb_hps_link;

	import hps_uio_pkg::*;
	import hps_fio_pkg::*;

	localparam int CHK_CFG      = 0;
	localparam int CHK_JOY0     = 1;
	localparam int CHK_JOY1     = 2;
	localparam int CHK_STATUS   = 3;
	localparam int CHK_READBACK = 4;
	localparam int CHK_INDEX    = 5;
	localparam int CHK_EXT      = 6;
	localparam int CHK_DL_START = 7;
	localparam int CHK_WR       = 8;
	localparam int CHK_DL_STOP  = 9;
	localparam int WR_TIMEOUT   = 20;

	typedef struct {
		bit                     fio;
		logic [`HPS_WORD_W-1:0] opcode;
		int                     nwords;
		string                  name;
		int                     check;
	} txn_t;

	logic                   clk_sys = 1'b0;
	logic                   arst_n;
	logic                   io_enable;
	logic                   fp_enable;
	logic                   io_strobe;
	logic [`HPS_WORD_W-1:0] io_din;
	status_t                status_in;
	logic                   status_set;
	logic [`HPS_WORD_W-1:0] io_dout;
	logic [1:0]             buttons;
	logic                   forced_scandoubler;
	logic [31:0]            joystick_0;
	logic [31:0]            joystick_1;
	status_t                status;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	ioctl_addr_t            ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic [31:0]            ioctl_file_ext;

	txn_t                   txns[$];
	logic [15:0]            lfsr = 16'd4;
	logic [`HPS_WORD_W-1:0] words [0:4];
	int                     dl_addr;
	logic [3:0]             req_cnt_m;
	status_t                status_req_m;

	always #4 clk_sys = ~clk_sys;

	hps_link_top u_hps_link_top (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_file_ext     (ioctl_file_ext)
	);

	// a failed bound assertion ends the run at once
	always @(u_hps_link_top.u_chk.fail_cnt) begin
		if (u_hps_link_top.u_chk.fail_cnt != 0) begin
			$display("a bound assertion failed, see the error above");
			$display("*** FAILED ***");
			$fatal(1, "assertion failure");
		end
	end

	////////////////////////////////////////////////////////////
	// random data and checks
	////////////////////////////////////////////////////////////

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	function automatic logic [15:0] rand_word();
		logic [15:0] w;
		w = '0;
		for (int b = 0; b < 16; b++) begin
			w[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_wr_pulse(input string name);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (!ioctl_wr && waited < WR_TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!ioctl_wr) begin
			$display("no ioctl_wr pulse seen in %s before the timeout", name);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	endtask

	////////////////////////////////////////////////////////////
	// host side drivers
	////////////////////////////////////////////////////////////

	task automatic strobe_word(input logic [`HPS_WORD_W-1:0] w);
		io_din    = w;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
	endtask

	// two rising edges, the core latches the last status_in
	task automatic pulse_status_set();
		for (int n = 0; n < 2; n++) begin
			status_in  = {rand_word(), rand_word(), rand_word(), rand_word()};
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
			@(negedge clk_sys);
			req_cnt_m    = req_cnt_m + 1'b1;
			status_req_m = status_in;
		end
	endtask

	function automatic void add_txn(input bit fio, input logic [15:0] opcode,
		input int nwords, input string name, input int check);
		txn_t t;
		t.fio    = fio;
		t.opcode = opcode;
		t.nwords = nwords;
		t.name   = name;
		t.check  = check;
		txns.push_back(t);
	endfunction

	task automatic check_result(input txn_t t);
		case (t.check)
			CHK_CFG: begin
				check_value({t.name, " buttons"}, words[1][1:0], buttons);
				check_value({t.name, " scandoubler"}, words[1][4], forced_scandoubler);
			end
			CHK_JOY0: check_value(t.name, {words[2], words[1]}, joystick_0);
			CHK_JOY1: check_value(t.name, {words[2], words[1]}, joystick_1);
			CHK_STATUS: check_value(t.name, {words[4], words[3], words[2], words[1]}, status);
			CHK_INDEX: check_value(t.name, words[1][7:0], ioctl_index);
			CHK_EXT: check_value(t.name, {words[1], words[2]}, ioctl_file_ext);
			CHK_DL_START: check_value({t.name, " download"}, 1'b1, ioctl_download);
			CHK_WR: check_value({t.name, " download"}, 1'b1, ioctl_download);
			CHK_DL_STOP: begin
				check_value({t.name, " download"}, 1'b0, ioctl_download);
				check_value({t.name, " final addr"}, dl_addr - 1, ioctl_addr);
			end
			default: ;
		endcase
		check_value({t.name, " idle io_dout"}, '0, io_dout);
	endtask

	task automatic play_txn(input txn_t t);
		logic [`HPS_WORD_W-1:0] exp_dout;
		words[0] = t.opcode;
		for (int i = 1; i <= t.nwords; i++) begin
			words[i] = rand_word();
		end
		if (t.check == CHK_DL_START) begin
			words[1][0] = 1'b1;
			dl_addr     = 0;
		end
		if (t.check == CHK_DL_STOP) begin
			words[1] = '0;
		end
		if (t.check == CHK_READBACK) begin
			pulse_status_set();
		end
		if (t.fio) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		@(negedge clk_sys);
		for (int i = 0; i <= t.nwords; i++) begin
			strobe_word(words[i]);
			if (t.check == CHK_WR && i > 0) begin
				wait_wr_pulse(t.name);
				check_value($sformatf("%s addr %0d", t.name, i), dl_addr, ioctl_addr);
				check_value($sformatf("%s data %0d", t.name, i), words[i][7:0], ioctl_dout);
				dl_addr++;
			end else begin
				@(negedge clk_sys);
			end
			// reply is registered two cycles after its strobe
			if (t.check == CHK_READBACK) begin
				if (i == 0) begin
					exp_dout = {8'd0, `HPS_REPLY_TAG, req_cnt_m};
				end else begin
					exp_dout = status_req_m[16*(i-1) +: 16];
				end
				check_value($sformatf("%s word %0d", t.name, i), exp_dout, io_dout);
			end
		end
		wait_cycles(3);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		wait_cycles(2);
		check_result(t);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		arst_n       = 1'b0;
		io_enable    = 1'b0;
		fp_enable    = 1'b0;
		io_strobe    = 1'b0;
		io_din       = '0;
		status_in    = '0;
		status_set   = 1'b0;
		req_cnt_m    = '0;
		status_req_m = '0;
		dl_addr      = 0;

		add_txn(1'b0, CMD_CFG, 1, "cfg", CHK_CFG);
		add_txn(1'b0, CMD_JOY0, 2, "joy0", CHK_JOY0);
		add_txn(1'b0, CMD_JOY1, 2, "joy1", CHK_JOY1);
		add_txn(1'b0, CMD_STATUS, 4, "status_wr", CHK_STATUS);
		add_txn(1'b0, CMD_STATUS_REQ, 4, "status_req", CHK_READBACK);
		add_txn(1'b1, FILE_INDEX, 1, "file_index", CHK_INDEX);
		add_txn(1'b1, FILE_INFO, 2, "file_info", CHK_EXT);
		add_txn(1'b1, FILE_TX, 1, "dl_start", CHK_DL_START);
		add_txn(1'b1, FILE_TX_DAT, 4, "dl_data", CHK_WR);
		add_txn(1'b1, FILE_TX, 1, "dl_stop", CHK_DL_STOP);

		wait_cycles(10);
		arst_n = 1'b1;
		wait_cycles(2);
		check_value("reset io_dout", '0, io_dout);
		check_value("reset download", 1'b0, ioctl_download);
		check_value("reset ioctl_wr", 1'b0, ioctl_wr);

		foreach (txns[i]) begin
			play_txn(txns[i]);
		end

		if (u_hps_link_top.u_chk.fail_cnt == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("%0d assertion failures", u_hps_link_top.u_chk.fail_cnt);
			$display("*** FAILED ***");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// ==== filelist.f ====
+incdir+.
hps_uio_pkg.sv
hps_fio_pkg.sv
hps_word_framer.sv
hps_user_regs.sv
hps_file_loader.sv
hps_link_top.sv
hps_link_chk.sv
tb_hps_link.sv
